// File: mem_xlate_pkg.sv
`default_nettype none

package mem_xlate_pkg;

    // TLB geometry
    localparam int tlb_entries = 8;
    localparam int page_offset_bits = 12;

    // memory operand ports per micro-op
    localparam int mem_ports = 2;

    // exception type bit positions
    localparam int ie_prot_bit = 0;
    localparam int ie_page_bit = 1;

    typedef logic [$clog2(tlb_entries)-1:0] tlb_idx_t;
    typedef logic [19:0] page_t;

    // one stored translation
    typedef struct packed {
        logic  valid;
        page_t vp;
        page_t pf;
        logic  present;
        // 1 means writable
        logic  rw;
        logic  pcd;
    } tlb_entry_t;

    // single-entry write request, applied at the next edge
    typedef struct packed {
        logic       en;
        tlb_idx_t   idx;
        tlb_entry_t entry;
    } tlb_fill_t;

    // rw bit 0 is read, bit 1 is write, zero means the operand is unused
    typedef struct packed {
        logic [1:0]  rw;
        logic [31:0] addr;
        logic [31:0] addr_end;
        logic [31:0] seg_limit;
    } mem_req_t;

    typedef struct packed {
        logic        hit;
        logic [31:0] paddr;
        logic        present;
        logic        rw;
    } tlb_result_t;

    // bit 0 protection, bit 1 page fault, bits 3..2 from decode
    typedef logic [3:0] ie_type_t;

endpackage

`default_nettype wire

// File: mem_uop_pkg.sv
`default_nettype none

package mem_uop_pkg;

    import mem_xlate_pkg::*;

    // operands and destinations per micro-op
    localparam int op_count = 4;

    // one-hot source positions
    localparam int src_count = 13;
    localparam int src_reg1 = 0;
    localparam int src_seg1 = 4;
    localparam int src_mem1 = 8;
    localparam int src_mem2 = 9;
    localparam int src_eip = 10;
    localparam int src_imm_lo = 11;
    localparam int src_imm_hi = 12;

    // destinations reuse this coding, only reg, seg and mem are legal there
    typedef logic [src_count-1:0] src_sel_t;

    typedef struct packed {
        // register number, segment number or physical address
        logic [31:0] addr;
        logic        is_reg;
        logic        is_seg;
        logic        is_mem;
    } dest_t;

    typedef struct packed {
        logic                           valid;
        logic [1:0]                     opsize;
        logic [31:0]                    eip;
        logic [47:0]                    imm;
        src_sel_t [op_count-1:0]        op_sel;
        src_sel_t [op_count-1:0]        dest_sel;
        logic [op_count-1:0][2:0]       reg_num;
        logic [op_count-1:0][2:0]       seg_num;
        logic [op_count-1:0]            res_ld;
        mem_req_t [mem_ports-1:0]       mem;
        logic                           ie;
        ie_type_t                       ie_type;
    } mem_uop_t;

    // values read from the register and segment files
    typedef struct packed {
        logic [op_count-1:0][63:0] reg_val;
        logic [op_count-1:0][15:0] seg_val;
    } reg_vals_t;

    // what the execute stage receives
    typedef struct packed {
        logic                      valid;
        logic [1:0]                opsize;
        logic [31:0]               eip;
        logic [op_count-1:0][63:0] op_val;
        dest_t [op_count-1:0]      dest;
        logic [op_count-1:0]       res_ld;
        logic                      ie;
        ie_type_t                  ie_type;
    } exec_uop_t;

endpackage

`default_nettype wire

// File: tlb.sv
`timescale 1ns/1ps
`default_nettype none

module tlb
    import mem_xlate_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,
    input  tlb_fill_t                   fill,
    input  mem_req_t [mem_ports-1:0]    req,
    output tlb_result_t [mem_ports-1:0] result
);

    tlb_entry_t entries [tlb_entries];

    // reset invalidates every entry
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < tlb_entries; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else if (fill.en) begin
            entries[fill.idx] <= fill.entry;
        end
    end

    // fully associative compare on each lookup port
    always_comb begin
        for (int p = 0; p < mem_ports; p++) begin
            result[p] = '0;
            // a miss passes the linear address through
            result[p].paddr = req[p].addr;

            // walk down so the lowest matching index is the last one written
            for (int i = tlb_entries - 1; i >= 0; i--) begin
                if (entries[i].valid &&
                    entries[i].vp == req[p].addr[31:page_offset_bits]) begin
                    result[p].hit = 1'b1;
                    result[p].paddr = {entries[i].pf,
                                       req[p].addr[page_offset_bits-1:0]};
                    result[p].present = entries[i].present;
                    result[p].rw = entries[i].rw;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: mem_fault_check.sv
`timescale 1ns/1ps
`default_nettype none

module mem_fault_check
    import mem_xlate_pkg::*;
(
    input  mem_req_t [mem_ports-1:0]    req,
    input  tlb_result_t [mem_ports-1:0] xlate,
    input  logic                        ie_in,
    input  ie_type_t                    ie_type_in,
    output logic                        ie,
    output ie_type_t                    ie_type
);

    logic [mem_ports-1:0] used;
    logic [mem_ports-1:0] seg_fault;
    logic [mem_ports-1:0] wr_fault;
    logic [mem_ports-1:0] page_fault;
    logic                 prot;
    logic                 pf;

    always_comb begin
        for (int p = 0; p < mem_ports; p++) begin
            used[p] = |req[p].rw;
            // last byte at or past the limit is outside the segment
            seg_fault[p] = used[p] && (req[p].addr_end >= req[p].seg_limit);
            // write to a read-only page
            wr_fault[p] = used[p] && xlate[p].hit && !xlate[p].rw && req[p].rw[1];
            // no page walk here, so a miss is reported as a fault
            page_fault[p] = used[p] && (!xlate[p].hit || !xlate[p].present);
        end
    end

    assign prot = |seg_fault || |wr_fault;
    assign pf = |page_fault;

    always_comb begin
        ie_type = ie_type_in;
        ie_type[ie_prot_bit] = prot;
        ie_type[ie_page_bit] = pf;
    end

    assign ie = ie_in || prot || pf;

endmodule

`default_nettype wire

// File: opswap.sv
`timescale 1ns/1ps
`default_nettype none

module opswap
    import mem_xlate_pkg::*;
    import mem_uop_pkg::*;
(
    input  src_sel_t [op_count-1:0]           op_sel,
    input  src_sel_t [op_count-1:0]           dest_sel,
    input  logic [op_count-1:0][2:0]          reg_num,
    input  logic [op_count-1:0][2:0]          seg_num,
    input  reg_vals_t                         regs,
    input  logic [mem_ports-1:0][63:0]        mem_data,
    input  logic [mem_ports-1:0][31:0]        paddr,
    input  logic [31:0]                       eip,
    input  logic [47:0]                       imm,
    output logic [op_count-1:0][63:0]         op_val,
    output dest_t [op_count-1:0]              dest
);

    logic [src_count-1:0][63:0] src_val;
    dest_t [src_count-1:0]      dest_src;

    // every value an operand can pick widened to 64 bits
    always_comb begin
        for (int i = 0; i < op_count; i++) begin
            src_val[src_reg1 + i] = regs.reg_val[i];
            src_val[src_seg1 + i] = {48'b0, regs.seg_val[i]};
        end
        src_val[src_mem1] = mem_data[0];
        src_val[src_mem2] = mem_data[1];
        src_val[src_eip] = {32'b0, eip};
        src_val[src_imm_lo] = {32'b0, imm[31:0]};
        src_val[src_imm_hi] = {48'b0, imm[47:32]};
    end

    // destination descriptor for each legal position
    always_comb begin
        dest_src = '0;
        for (int i = 0; i < op_count; i++) begin
            dest_src[src_reg1 + i].addr = {29'b0, reg_num[i]};
            dest_src[src_reg1 + i].is_reg = 1'b1;
            dest_src[src_seg1 + i].addr = {29'b0, seg_num[i]};
            dest_src[src_seg1 + i].is_seg = 1'b1;
        end
        dest_src[src_mem1].addr = paddr[0];
        dest_src[src_mem1].is_mem = 1'b1;
        dest_src[src_mem2].addr = paddr[1];
        dest_src[src_mem2].is_mem = 1'b1;
        // eip and immediate positions stay zero as destinations
    end

    // and-or mux where an empty select falls out as zero
    always_comb begin
        for (int k = 0; k < op_count; k++) begin
            op_val[k] = '0;
            for (int s = 0; s < src_count; s++) begin
                if (op_sel[k][s]) begin
                    op_val[k] = op_val[k] | src_val[s];
                end
            end
        end
    end

    always_comb begin
        for (int k = 0; k < op_count; k++) begin
            dest[k] = '0;
            for (int s = 0; s < src_count; s++) begin
                if (dest_sel[k][s]) begin
                    dest[k] = dest[k] | dest_src[s];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage
    import mem_xlate_pkg::*;
    import mem_uop_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  mem_uop_t    uop_in,
    input  reg_vals_t   regs_in,
    input  logic [63:0] mem1_data,
    input  logic [63:0] mem2_data,
    input  tlb_fill_t   tlb_fill,
    input  logic        fwd_stall,
    output exec_uop_t   uop_out,
    output logic        stall,
    output logic [31:0] paddr1,
    output logic [31:0] paddr2
);

    tlb_result_t [mem_ports-1:0]  xlate;
    logic [mem_ports-1:0][31:0]   paddr;
    logic [mem_ports-1:0][63:0]   mem_data;
    logic [op_count-1:0][63:0]    op_val;
    dest_t [op_count-1:0]         dest;
    logic                         ie;
    ie_type_t                     ie_type;
    exec_uop_t                    uop_next;

    tlb u_tlb (
        .clk    (clk),
        .reset  (reset),
        .fill   (tlb_fill),
        .req    (uop_in.mem),
        .result (xlate)
    );

    mem_fault_check u_fault (
        .req        (uop_in.mem),
        .xlate      (xlate),
        .ie_in      (uop_in.ie),
        .ie_type_in (uop_in.ie_type),
        .ie         (ie),
        .ie_type    (ie_type)
    );

    // translated addresses feed both the cache and the memory destinations
    always_comb begin
        for (int p = 0; p < mem_ports; p++) begin
            paddr[p] = xlate[p].paddr;
        end
    end

    assign mem_data = {mem2_data, mem1_data};

    opswap u_opswap (
        .op_sel   (uop_in.op_sel),
        .dest_sel (uop_in.dest_sel),
        .reg_num  (uop_in.reg_num),
        .seg_num  (uop_in.seg_num),
        .regs     (regs_in),
        .mem_data (mem_data),
        .paddr    (paddr),
        .eip      (uop_in.eip),
        .imm      (uop_in.imm),
        .op_val   (op_val),
        .dest     (dest)
    );

    assign paddr1 = paddr[0];
    assign paddr2 = paddr[1];

    // next value of the stage register
    always_comb begin
        uop_next.valid = uop_in.valid;
        uop_next.opsize = uop_in.opsize;
        uop_next.eip = uop_in.eip;
        uop_next.op_val = op_val;
        uop_next.dest = dest;
        uop_next.res_ld = uop_in.res_ld;
        // an empty slot carries no exception
        uop_next.ie = uop_in.valid && ie;
        uop_next.ie_type = uop_in.valid ? ie_type : '0;
    end

    // hold upstream while execute is stalled on forwarding
    assign stall = fwd_stall && uop_in.valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            uop_out.valid <= 1'b0;
            uop_out.ie <= 1'b0;
            uop_out.ie_type <= '0;
        end else if (!fwd_stall) begin
            uop_out <= uop_next;
        end
    end

endmodule

`default_nettype wire

// File: mem_stage_assert.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage_assert
    import mem_uop_pkg::*;
(
    input logic      clk,
    input logic      reset,
    input logic      fwd_stall,
    input exec_uop_t uop_out
);

    // stage register comes out of reset empty
    valid_after_reset: assert property (
        @(posedge clk) reset |=> !uop_out.valid
    ) else $error("uop_out.valid is set in the cycle after reset");

    // a forwarding stall freezes what execute sees
    hold_on_stall: assert property (
        @(posedge clk) disable iff (reset) fwd_stall |=> $stable(uop_out)
    ) else $error("uop_out changed while fwd_stall was high");

    // protection or page fault must also raise ie
    fault_sets_ie: assert property (
        @(posedge clk) disable iff (reset)
            (uop_out.valid && (uop_out.ie_type[1:0] != 2'b00)) |-> uop_out.ie
    ) else $error("fault bit set in ie_type without ie on a valid output");

endmodule

`default_nettype wire

// File: tb_mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_stage
    import mem_xlate_pkg::*;
    import mem_uop_pkg::*;
();

    localparam int row_count = 14;
    localparam int cycle_limit = 8 + 8 + 2 * row_count + 20;
    localparam src_sel_t no_sel = '0;

    typedef logic [447:0] wide_t;

    typedef struct packed {
        logic                          valid;
        src_sel_t [op_count-1:0]       op_sel;
        src_sel_t [op_count-1:0]       dest_sel;
        logic [op_count-1:0][2:0]      reg_num;
        logic [op_count-1:0][2:0]      seg_num;
        mem_req_t [mem_ports-1:0]      mem;
        logic                          ie_in;
        ie_type_t                      ie_type_in;
        logic                          fwd;
        logic                          exp_ie;
        ie_type_t                      exp_type;
        logic                          exp_stall;
        logic                          hold;
    } row_t;

    logic        clk;
    logic        reset;
    mem_uop_t    uop_in;
    reg_vals_t   regs_in;
    logic [63:0] mem1_data;
    logic [63:0] mem2_data;
    tlb_fill_t   tlb_fill;
    logic        fwd_stall;
    exec_uop_t   uop_out;
    logic        stall;
    logic [31:0] paddr1;
    logic [31:0] paddr2;

    row_t       rows [row_count];
    string      names [row_count];
    tlb_entry_t tlb_copy [tlb_entries];
    int         check_count = 0;
    int         value_errors = 0;
    int         cycles = 0;

    mem_stage u_mem_stage (
        .clk       (clk),
        .reset     (reset),
        .uop_in    (uop_in),
        .regs_in   (regs_in),
        .mem1_data (mem1_data),
        .mem2_data (mem2_data),
        .tlb_fill  (tlb_fill),
        .fwd_stall (fwd_stall),
        .uop_out   (uop_out),
        .stall     (stall),
        .paddr1    (paddr1),
        .paddr2    (paddr2)
    );

    bind mem_stage mem_stage_assert u_assert (
        .clk       (clk),
        .reset     (reset),
        .fwd_stall (fwd_stall),
        .uop_out   (uop_out)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("checks %0d, value errors %0d", check_count, value_errors);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic src_sel_t one_hot(input int pos);
        src_sel_t s;
        s = '0;
        s[pos] = 1'b1;
        return s;
    endfunction

    function automatic mem_req_t mem_op(input logic [1:0] rw, input logic [31:0] addr,
                                        input logic [31:0] limit);
        mem_req_t r;
        r.rw = rw;
        r.addr = addr;
        // eight-byte access
        r.addr_end = addr + 32'd7;
        r.seg_limit = limit;
        return r;
    endfunction

    function automatic int sel_pos(input src_sel_t s);
        int pos;
        pos = -1;
        for (int b = 0; b < src_count; b++) begin
            if (s[b]) begin
                pos = b;
            end
        end
        return pos;
    endfunction

    // first matching entry in index order wins
    function automatic tlb_result_t expect_xlate(input logic [31:0] addr);
        tlb_result_t r;
        r = '0;
        r.paddr = addr;
        for (int e = 0; e < tlb_entries; e++) begin
            if (!r.hit && tlb_copy[e].valid && tlb_copy[e].vp == addr[31:12]) begin
                r.hit = 1'b1;
                r.paddr = {tlb_copy[e].pf, addr[11:0]};
                r.present = tlb_copy[e].present;
                r.rw = tlb_copy[e].rw;
            end
        end
        return r;
    endfunction

    function automatic logic [63:0] expect_op(input src_sel_t s);
        int pos;
        pos = sel_pos(s);
        case (pos)
            0, 1, 2, 3: return regs_in.reg_val[pos[1:0]];
            4, 5, 6, 7: return {48'h0, regs_in.seg_val[pos[1:0]]};
            8: return mem1_data;
            9: return mem2_data;
            10: return {32'h0, uop_in.eip};
            11: return {32'h0, uop_in.imm[31:0]};
            12: return {48'h0, uop_in.imm[47:32]};
            default: return '0;
        endcase
    endfunction

    function automatic dest_t expect_dest(input src_sel_t s, input int i);
        dest_t d;
        tlb_result_t r;
        int pos;
        d = '0;
        pos = sel_pos(s);
        if (pos >= 0 && pos < 4) begin
            d.addr = {29'h0, rows[i].reg_num[pos[1:0]]};
            d.is_reg = 1'b1;
        end else if (pos >= 4 && pos < 8) begin
            d.addr = {29'h0, rows[i].seg_num[pos[1:0]]};
            d.is_seg = 1'b1;
        end else if (pos == 8 || pos == 9) begin
            r = expect_xlate(rows[i].mem[pos[0]].addr);
            d.addr = r.paddr;
            d.is_mem = 1'b1;
        end
        return d;
    endfunction

    function automatic exec_uop_t expected_out(input int i);
        exec_uop_t e;
        e = '0;
        e.valid = 1'b1;
        e.opsize = uop_in.opsize;
        e.eip = uop_in.eip;
        e.res_ld = uop_in.res_ld;
        for (int k = 0; k < op_count; k++) begin
            e.op_val[k] = expect_op(rows[i].op_sel[k]);
            e.dest[k] = expect_dest(rows[i].dest_sel[k], i);
        end
        e.ie = rows[i].exp_ie;
        e.ie_type = rows[i].exp_type;
        return e;
    endfunction

    task automatic check_field(input string test, input string field,
                               input wide_t expected, input wide_t actual);
        check_count++;
        assert (actual === expected) else begin
            value_errors++;
            $display("error %s %s: expected %0h actual %0h", test, field, expected, actual);
        end
    endtask

    task automatic set_row(input int i, input string name, input src_sel_t [3:0] ops,
                           input src_sel_t [3:0] dsts);
        names[i] = name;
        rows[i] = '0;
        rows[i].valid = 1'b1;
        rows[i].op_sel = ops;
        rows[i].dest_sel = dsts;
        rows[i].reg_num = 12'(i * 12'o1234 + 12'o0765);
        rows[i].seg_num = ~rows[i].reg_num;
    endtask

    task automatic build_table();
        set_row(0, "regs", {one_hot(3), one_hot(2), one_hot(1), one_hot(0)},
                {one_hot(3), one_hot(2), one_hot(1), one_hot(0)});
        set_row(1, "segs", {one_hot(7), one_hot(6), one_hot(5), one_hot(4)},
                {one_hot(7), one_hot(6), one_hot(5), one_hot(4)});
        set_row(2, "eip_imm", {no_sel, one_hot(12), one_hot(11), one_hot(10)},
                {no_sel, no_sel, one_hot(0), one_hot(4)});
        set_row(3, "mem_map", {one_hot(9), one_hot(8), one_hot(0), one_hot(1)},
                {one_hot(9), one_hot(8), one_hot(2), no_sel});
        rows[3].mem[0] = mem_op(2'b01, 32'h0001_2345, 32'hffff_0000);
        rows[3].mem[1] = mem_op(2'b11, 32'h0001_6008, 32'hffff_0000);
        set_row(4, "unmapped", {no_sel, no_sel, no_sel, one_hot(8)},
                {no_sel, no_sel, no_sel, one_hot(8)});
        rows[4].mem[0] = mem_op(2'b01, 32'h0004_0100, 32'hffff_0000);
        {rows[4].exp_ie, rows[4].exp_type} = 5'b1_0010;
        set_row(5, "not_present", {no_sel, no_sel, no_sel, one_hot(8)},
                {no_sel, no_sel, no_sel, one_hot(8)});
        rows[5].mem[0] = mem_op(2'b01, 32'h0001_5000, 32'hffff_0000);
        {rows[5].exp_ie, rows[5].exp_type} = 5'b1_0010;
        set_row(6, "seg_limit", {no_sel, no_sel, no_sel, one_hot(8)},
                {no_sel, no_sel, no_sel, one_hot(8)});
        rows[6].mem[0] = mem_op(2'b01, 32'h0001_0ff8, 32'h0001_0ffc);
        {rows[6].exp_ie, rows[6].exp_type} = 5'b1_0001;
        set_row(7, "read_only", {no_sel, no_sel, one_hot(9), no_sel},
                {one_hot(9), no_sel, no_sel, no_sel});
        rows[7].mem[1] = mem_op(2'b10, 32'h0001_3020, 32'hffff_0000);
        {rows[7].exp_ie, rows[7].exp_type} = 5'b1_0001;
        set_row(8, "carry", {one_hot(0), one_hot(1), one_hot(2), one_hot(3)},
                {no_sel, no_sel, no_sel, one_hot(2)});
        {rows[8].ie_in, rows[8].ie_type_in} = 5'b1_1111;
        {rows[8].exp_ie, rows[8].exp_type} = 5'b1_1100;
        set_row(9, "stall_hold", {one_hot(4), one_hot(5), one_hot(6), one_hot(7)},
                {one_hot(4), no_sel, no_sel, no_sel});
        {rows[9].fwd, rows[9].exp_stall, rows[9].hold} = 3'b111;
        set_row(10, "release", {one_hot(0), one_hot(12), one_hot(9), one_hot(4)},
                {no_sel, one_hot(9), one_hot(5), one_hot(1)});
        rows[10].mem[1] = mem_op(2'b01, 32'h0001_1abc, 32'hffff_0000);
        set_row(11, "stall_idle", {no_sel, no_sel, no_sel, one_hot(0)},
                {no_sel, no_sel, no_sel, one_hot(0)});
        {rows[11].valid, rows[11].fwd, rows[11].hold} = 3'b011;
        set_row(12, "invalid", {no_sel, no_sel, no_sel, one_hot(1)},
                {no_sel, no_sel, no_sel, one_hot(1)});
        rows[12].valid = 1'b0;
        set_row(13, "both_fault", {no_sel, no_sel, one_hot(9), one_hot(8)},
                {no_sel, no_sel, one_hot(9), one_hot(8)});
        rows[13].mem[0] = mem_op(2'b01, 32'h0004_0000, 32'hffff_0000);
        rows[13].mem[1] = mem_op(2'b01, 32'h0001_7ff8, 32'h0001_7ffc);
        rows[13].ie_type_in = 4'b0100;
        {rows[13].exp_ie, rows[13].exp_type} = 5'b1_0111;
    endtask

    // entry 5 not present, entry 3 read-only, page 0x00040 stays unmapped
    task automatic load_tlb();
        tlb_entry_t e;
        for (int i = 0; i < tlb_entries; i++) begin
            @(negedge clk);
            e.valid = 1'b1;
            e.vp = 20'h00010 + 20'(i);
            e.pf = 20'h00a00 + 20'(i * 16);
            e.present = (i != 5);
            e.rw = (i != 3);
            e.pcd = 1'(i);
            tlb_copy[i] = e;
            tlb_fill.en = 1'b1;
            tlb_fill.idx = tlb_idx_t'(i);
            tlb_fill.entry = e;
        end
    endtask

    task automatic drive_row(input int i);
        uop_in = '0;
        uop_in.valid = rows[i].valid;
        uop_in.opsize = 2'(i);
        uop_in.eip = $urandom;
        uop_in.imm = {16'($urandom), $urandom};
        uop_in.op_sel = rows[i].op_sel;
        uop_in.dest_sel = rows[i].dest_sel;
        uop_in.reg_num = rows[i].reg_num;
        uop_in.seg_num = rows[i].seg_num;
        uop_in.res_ld = 4'(i);
        uop_in.mem = rows[i].mem;
        uop_in.ie = rows[i].ie_in;
        uop_in.ie_type = rows[i].ie_type_in;
        for (int k = 0; k < op_count; k++) begin
            regs_in.reg_val[k] = {$urandom, $urandom};
            regs_in.seg_val[k] = 16'($urandom);
        end
        // cache read data for this cycle
        mem1_data = {$urandom, $urandom};
        mem2_data = {$urandom, $urandom};
        fwd_stall = rows[i].fwd;
    endtask

    initial begin
        exec_uop_t   want;
        exec_uop_t   prev;
        tlb_result_t x0;
        tlb_result_t x1;
        void'($urandom(26118));
        reset = 1'b1;
        uop_in = '0;
        regs_in = '0;
        mem1_data = '0;
        mem2_data = '0;
        tlb_fill = '0;
        fwd_stall = 1'b0;
        prev = '0;
        build_table();

        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        #1;
        check_field("reset", "valid", wide_t'(1'b0), wide_t'(uop_out.valid));
        check_field("reset", "ie", wide_t'(1'b0), wide_t'(uop_out.ie));
        check_field("reset", "stall", wide_t'(1'b0), wide_t'(stall));

        load_tlb();
        @(negedge clk);
        tlb_fill = '0;

        for (int i = 0; i < row_count; i++) begin
            drive_row(i);
            x0 = expect_xlate(rows[i].mem[0].addr);
            x1 = expect_xlate(rows[i].mem[1].addr);
            want = rows[i].hold ? prev : expected_out(i);
            #1;
            check_field(names[i], "stall", wide_t'(rows[i].exp_stall), wide_t'(stall));
            check_field(names[i], "paddr1", wide_t'(x0.paddr), wide_t'(paddr1));
            check_field(names[i], "paddr2", wide_t'(x1.paddr), wide_t'(paddr2));
            @(posedge clk);
            #1;
            if (rows[i].hold || rows[i].valid) begin
                check_field(names[i], "ie_type", wide_t'({want.ie, want.ie_type}),
                            wide_t'({uop_out.ie, uop_out.ie_type}));
                check_field(names[i], "uop_out", wide_t'(want), wide_t'(uop_out));
            end else begin
                check_field(names[i], "valid", wide_t'(1'b0), wide_t'(uop_out.valid));
            end
            if (rows[i].valid && !rows[i].hold) begin
                prev = want;
            end
            @(negedge clk);
        end

        $display("checks %0d, value errors %0d", check_count, value_errors);
        if (value_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
mem_xlate_pkg.sv
mem_uop_pkg.sv
tlb.sv
mem_fault_check.sv
opswap.sv
mem_stage.sv
mem_stage_assert.sv
tb_mem_stage.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_mem_stage
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
JOBS ?= 0
VFLAGS ?= --binary --timing --assert -j $(JOBS)
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG ?= All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$($(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
